/* Makefile */
SIM  := obj_dir/Vtb_conv_post
SRCS := $(shell cat conv_post.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): conv_post.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		-f conv_post.f --top-module tb_conv_post -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	@grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* conv_post.f */
hdl/conv_cfg_pkg.sv
hdl/conv_types_pkg.sv
hdl/conv_post_ifs.sv
hdl/scale_table.sv
hdl/requant_lane.sv
hdl/lane_fifo.sv
hdl/out_arbiter.sv
hdl/conv_post_top.sv
verif/tb_conv_post.sv

/* hdl/conv_cfg_pkg.sv */
`default_nettype none

package conv_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // lanes and channels
    //////////////////////////////////////////////////////////////////////
    localparam int NUM_LANES   = 3;   // one lane per array column
    localparam int NUM_CHANS   = 4;
    localparam int CHAN_W      = 2;
    localparam int LANE_W      = 2;

    //////////////////////////////////////////////////////////////////////
    // datapath widths
    //////////////////////////////////////////////////////////////////////
    localparam int ACC_W       = 24;
    localparam int BIAS_W      = 8;   // signed
    localparam int TAIL_W      = 16;  // unsigned
    localparam int RANK_W      = 5;   // shifts 0..31
    localparam int QUANT_W     = 8;
    localparam int SUM_W       = ACC_W + 1;           // acc plus bias, no overflow
    localparam int PROD_W      = SUM_W + TAIL_W + 1;  // signed times unsigned
    localparam int QUANT_MAX   = (1 << (QUANT_W - 1)) - 1;
    localparam int QUANT_MIN   = -(1 << (QUANT_W - 1));

    // queues and credits
    localparam int FIFO_DEPTH  = 4;   // also the initial input credits per lane
    localparam int PTR_W       = $clog2(FIFO_DEPTH);
    localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);
    localparam int OUT_CREDITS = 4;
    localparam int OCNT_W      = $clog2(OUT_CREDITS + 1);

endpackage

`default_nettype wire

/* hdl/conv_post_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

//////////////////////////////////////////////////////////////////////
// scale lookup, lane to table
//////////////////////////////////////////////////////////////////////
interface scale_rd_if import conv_cfg_pkg::*; ();

    logic [CHAN_W-1:0]        chan;
    logic signed [BIAS_W-1:0] bias;
    logic [TAIL_W-1:0]        tail;
    logic [RANK_W-1:0]        rank;

    modport lane (
        output chan,
        input  bias,
        input  tail,
        input  rank
    );

    modport tbl (
        input  chan,
        output bias,
        output tail,
        output rank
    );

endinterface

//////////////////////////////////////////////////////////////////////
// lane queue, fifo to arbiter
//////////////////////////////////////////////////////////////////////
interface lane_q_if import conv_types_pkg::*; ();

    logic         avail;   // queue not empty
    lane_result_t head;    // front entry
    logic         pop;     // only while avail
    logic         credit;  // one pulse per pop, a cycle later

    modport queue (output avail, output head, input pop, output credit);

    modport arb (input avail, input head, output pop, input credit);

endinterface

`default_nettype wire

/* hdl/conv_post_top.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_post_top import conv_cfg_pkg::*, conv_types_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_LANES-1:0] in_valid,
    input  logic [ACC_W-1:0]     in_acc0,
    input  logic [ACC_W-1:0]     in_acc1,
    input  logic [ACC_W-1:0]     in_acc2,
    input  logic [CHAN_W-1:0]    in_chan0,
    input  logic [CHAN_W-1:0]    in_chan1,
    input  logic [CHAN_W-1:0]    in_chan2,
    output logic [NUM_LANES-1:0] in_credit,
    input  logic                 cfg_we,
    input  logic [CHAN_W-1:0]    cfg_chan,
    input  logic [BIAS_W-1:0]    cfg_bias,
    input  logic [TAIL_W-1:0]    cfg_tail,
    input  logic [RANK_W-1:0]    cfg_rank,
    input  logic                 out_credit,
    output logic                 out_valid,
    output logic [LANE_W-1:0]    out_lane,
    output logic [CHAN_W-1:0]    out_chan,
    output logic [QUANT_W-1:0]   out_data
);

    scale_entry_t      cfg_entry;
    acc_t              lane_acc       [NUM_LANES];
    logic [CHAN_W-1:0] lane_chan      [NUM_LANES];
    logic              lane_push      [NUM_LANES];
    lane_result_t      lane_push_data [NUM_LANES];

    scale_rd_if rd_if [NUM_LANES] ();
    lane_q_if   q_if  [NUM_LANES] ();

    assign cfg_entry.bias = cfg_bias;
    assign cfg_entry.tail = cfg_tail;
    assign cfg_entry.rank = cfg_rank;

    assign lane_acc[0]  = in_acc0;
    assign lane_acc[1]  = in_acc1;
    assign lane_acc[2]  = in_acc2;
    assign lane_chan[0] = in_chan0;
    assign lane_chan[1] = in_chan1;
    assign lane_chan[2] = in_chan2;

    scale_table u_scale_table (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_chan  (cfg_chan),
        .cfg_entry (cfg_entry),
        .rd        (rd_if)
    );

    //////////////////////////////////////////////////////////////////////
    // per-lane pipeline and queue
    //////////////////////////////////////////////////////////////////////
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        requant_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (in_valid[g]),
            .in_acc    (lane_acc[g]),
            .in_chan   (lane_chan[g]),
            .scale     (rd_if[g]),
            .push      (lane_push[g]),
            .push_data (lane_push_data[g])
        );

        lane_fifo u_fifo (
            .clk       (clk),
            .reset     (reset),
            .push      (lane_push[g]),
            .push_data (lane_push_data[g]),
            .q         (q_if[g])
        );

        assign in_credit[g] = q_if[g].credit;  // back to the producer
    end

    out_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .q          (q_if),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_lane   (out_lane),
        .out_chan   (out_chan),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

/* hdl/conv_types_pkg.sv */
`default_nettype none

package conv_types_pkg;

    import conv_cfg_pkg::*;

    // raw partial sum from the array column
    typedef logic signed [ACC_W-1:0] acc_t;

    // quantized output pixel
    typedef logic signed [QUANT_W-1:0] quant_t;

    // per-channel requant parameters, 29 bits
    typedef struct packed {
        logic signed [BIAS_W-1:0] bias;
        logic [TAIL_W-1:0]        tail;  // E-scale tail
        logic [RANK_W-1:0]        rank;  // E-scale rank, right shift
    } scale_entry_t;

    // one queued result, 10 bits
    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        quant_t            data;
    } lane_result_t;

endpackage

`default_nettype wire

/* hdl/lane_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_fifo import conv_cfg_pkg::*, conv_types_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         push,
    input  lane_result_t push_data,
    lane_q_if.queue      q
);

    lane_result_t     mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign q.avail = (count != '0);
    assign q.head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers, count, credit return
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            q.credit <= 1'b0;
        end else begin
            q.credit <= q.pop;  // one credit per pop
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (q.pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, q.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // input credits bound everything in flight to the queue depth
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

    // arbiter only pops an available lane
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        q.pop |-> q.avail);

endmodule

`default_nettype wire

/* hdl/out_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module out_arbiter import conv_cfg_pkg::*, conv_types_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    lane_q_if.arb             q [NUM_LANES],
    input  logic              out_credit,
    output logic              out_valid,
    output logic [LANE_W-1:0] out_lane,
    output logic [CHAN_W-1:0] out_chan,
    output quant_t            out_data
);

    logic [NUM_LANES-1:0] avail_vec;
    lane_result_t         head_vec [NUM_LANES];
    logic [LANE_W-1:0]    last_lane;
    logic [LANE_W-1:0]    grant_lane;
    logic                 grant_valid;
    logic [OCNT_W-1:0]    ocnt;
    logic                 can_send;
    logic                 pop_en;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign avail_vec[g] = q[g].avail;
        assign head_vec[g]  = q[g].head;
        assign q[g].pop     = pop_en && (grant_lane == LANE_W'(g));
    end

    //////////////////////////////////////////////////////////////////////
    // round robin, search starts after the last grant
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_lane  = '0;
        for (int i = 1; i <= NUM_LANES; i++) begin
            idx = (int'(last_lane) + i) % NUM_LANES;
            if (!grant_valid && avail_vec[idx]) begin
                grant_valid = 1'b1;
                grant_lane  = LANE_W'(idx);
            end
        end
    end

    // a credit arriving now may be spent at once
    assign can_send = (ocnt != '0) || out_credit;
    assign pop_en   = grant_valid && can_send;

    always_ff @(posedge clk) begin
        if (reset) begin
            ocnt      <= OCNT_W'(OUT_CREDITS);
            last_lane <= LANE_W'(NUM_LANES - 1);  // lane 0 goes first
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop_en;
            if (pop_en) begin
                last_lane <= grant_lane;
            end
            case ({pop_en, out_credit})
                2'b10:   ocnt <= ocnt - 1'b1;
                2'b01:   ocnt <= ocnt + 1'b1;
                default: ocnt <= ocnt;  // spend and return cancel
            endcase
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        if (pop_en) begin
            out_lane <= grant_lane;
            out_chan <= head_vec[grant_lane].chan;
            out_data <= head_vec[grant_lane].data;
        end
    end

    // consumer never returns more credits than it was given
    a_ocnt_bound: assert property (@(posedge clk) disable iff (reset)
        ocnt <= OCNT_W'(OUT_CREDITS));

endmodule

`default_nettype wire

/* hdl/requant_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module requant_lane import conv_cfg_pkg::*, conv_types_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  acc_t              in_acc,
    input  logic [CHAN_W-1:0] in_chan,
    scale_rd_if.lane          scale,
    output logic              push,
    output lane_result_t      push_data
);

    logic signed [SUM_W-1:0]  sum_next;
    logic                     s1_valid;
    logic signed [SUM_W-1:0]  s1_sum;
    logic [TAIL_W-1:0]        s1_tail;
    logic [RANK_W-1:0]        s1_rank;
    logic [CHAN_W-1:0]        s1_chan;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] rnd;
    logic signed [PROD_W-1:0] shifted;
    quant_t                   sat;

    //////////////////////////////////////////////////////////////////////
    // stage 1, bias add
    //////////////////////////////////////////////////////////////////////
    assign scale.chan = in_chan;
    assign sum_next = {in_acc[ACC_W-1], in_acc}
                    + {{(SUM_W - BIAS_W){scale.bias[BIAS_W-1]}}, scale.bias};

    always_ff @(posedge clk) begin
        s1_sum  <= sum_next;
        s1_tail <= scale.tail;  // scale captured with the sum
        s1_rank <= scale.rank;
        s1_chan <= in_chan;
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2, scale, round, saturate
    //////////////////////////////////////////////////////////////////////
    assign prod = s1_sum * $signed({1'b0, s1_tail});  // tail is unsigned
    assign rnd  = (s1_rank != '0) ? (PROD_W'(1) << (s1_rank - 1)) : '0;
    assign shifted = (prod + rnd) >>> s1_rank;

    always_comb begin
        if (shifted > QUANT_MAX) begin
            sat = QUANT_W'(QUANT_MAX);
        end else if (shifted < QUANT_MIN) begin
            sat = QUANT_W'(QUANT_MIN);
        end else begin
            sat = shifted[QUANT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        push_data.chan <= s1_chan;
        push_data.data <= sat;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            push     <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            push     <= s1_valid;  // two cycles after in_valid
        end
    end

    // a zero tail in the table would flatten every result of that channel
    a_tail_nonzero: assert property (@(posedge clk) disable iff (reset)
        s1_valid |-> (s1_tail != '0));

endmodule

`default_nettype wire

/* hdl/scale_table.sv */
`timescale 1ns/1ns
`default_nettype none

module scale_table import conv_cfg_pkg::*, conv_types_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              cfg_we,
    input  logic [CHAN_W-1:0] cfg_chan,
    input  scale_entry_t      cfg_entry,
    scale_rd_if.tbl           rd [NUM_LANES]
);

    scale_entry_t entries [NUM_CHANS];

    // write port, one entry per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < NUM_CHANS; c++) begin
                entries[c].bias <= '0;
                entries[c].tail <= TAIL_W'(1);  // unity scale
                entries[c].rank <= '0;
            end
        end else if (cfg_we) begin
            entries[cfg_chan] <= cfg_entry;
        end
    end

    // one async read port per lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_rd
        assign rd[g].bias = entries[rd[g].chan].bias;
        assign rd[g].tail = entries[rd[g].chan].tail;
        assign rd[g].rank = entries[rd[g].chan].rank;
    end

endmodule

`default_nettype wire

/* verif/tb_conv_post.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_conv_post import conv_cfg_pkg::*; ();

    localparam int NROWS       = 30;
    localparam int NPHASES     = 2;
    localparam int HOLD_PHASE  = 1;   // consumer withholds output credit here
    localparam int HOLD_CYCLES = 40;
    localparam int WATCHDOG    = NROWS * 30 + 200;

    // scale entries per phase and channel as 32'hBB_TTTT_RR with bias, tail and rank
    localparam logic [31:0] CFG_TAB [NPHASES*NUM_CHANS] = '{
        32'h00_0001_00, 32'h05_0003_02, 32'hF0_0100_08, 32'h00_C000_10,
        32'h7F_0002_01, 32'h80_00FF_04, 32'h00_FFFF_1F, 32'h10_0005_03
    };

    // stimulus rows as 36'hP_L_C_AAAAAA with phase, lane, channel and accumulator
    localparam logic [35:0] STIM [NROWS] = '{
        36'h0_0_0_000050, 36'h0_1_1_000007, 36'h0_2_2_000050,
        36'h0_0_0_000200, 36'h0_1_1_FFFFF8, 36'h0_2_3_000020,
        36'h0_0_0_FFFE00, 36'h0_1_3_FFFFE0, 36'h0_2_2_FFFF00,
        36'h0_0_3_000100, 36'h0_1_0_FFFFF9, 36'h0_2_1_7FFFFF,
        36'h1_0_0_FFFF80, 36'h1_1_1_000085, 36'h1_2_2_7FFFFF,
        36'h1_0_3_FFFFC0, 36'h1_1_2_010000, 36'h1_2_0_000010,
        36'h1_0_1_FFFF00, 36'h1_1_3_000040, 36'h1_2_2_004000,
        36'h1_0_2_800000, 36'h1_1_0_FFFF70, 36'h1_2_3_FFF000,
        36'h1_0_0_000003, 36'h1_1_1_000090, 36'h1_2_1_FFFFFF,
        36'h1_0_3_000007, 36'h1_1_2_FF0000, 36'h1_2_0_FFFF81
    };

    logic                 clk = 1'b0;
    logic                 reset;
    logic [NUM_LANES-1:0] in_valid;
    logic [ACC_W-1:0]     acc_drv  [NUM_LANES];
    logic [CHAN_W-1:0]    chan_drv [NUM_LANES];
    logic [NUM_LANES-1:0] in_credit;
    logic                 cfg_we;
    logic [CHAN_W-1:0]    cfg_chan;
    logic [BIAS_W-1:0]    cfg_bias;
    logic [TAIL_W-1:0]    cfg_tail;
    logic [RANK_W-1:0]    cfg_rank;
    logic                 out_credit;
    logic                 out_valid;
    logic [LANE_W-1:0]    out_lane;
    logic [CHAN_W-1:0]    out_chan;
    logic [QUANT_W-1:0]   out_data;

    logic [9:0] exp_q [NUM_LANES][$];   // {chan, byte} per lane in send order
    logic [9:0] exp_head;
    int         credits    [NUM_LANES];  // producer side input credits
    int         sent_beats [NUM_LANES];
    int         returned   [NUM_LANES];
    int         gap_tab    [64];
    int         gap_idx = 0;
    int         gap = 0;
    int         owed = 0;                // beats not yet credited back
    int         out_beats = 0;
    int         credits_given = 0;
    int         mismatches = 0;
    int         errors = 0;
    int         seed_rv;
    logic       withhold = 1'b0;

    always #2 clk = ~clk;

    conv_post_top u_dut (
        .clk (clk), .reset (reset), .in_valid (in_valid),
        .in_acc0 (acc_drv[0]), .in_acc1 (acc_drv[1]), .in_acc2 (acc_drv[2]),
        .in_chan0 (chan_drv[0]), .in_chan1 (chan_drv[1]), .in_chan2 (chan_drv[2]),
        .in_credit (in_credit), .cfg_we (cfg_we), .cfg_chan (cfg_chan),
        .cfg_bias (cfg_bias), .cfg_tail (cfg_tail), .cfg_rank (cfg_rank),
        .out_credit (out_credit), .out_valid (out_valid), .out_lane (out_lane),
        .out_chan (out_chan), .out_data (out_data)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [9:0] expected_result(input logic [35:0] row,
                                                   input logic [31:0] entry);
        longint v;
        int     rank;
        rank = int'(entry[4:0]);
        v = longint'($signed(row[23:0])) + longint'($signed(entry[31:24]));
        v = v * longint'(entry[23:8]);  // tail taken as unsigned
        if (rank > 0) begin
            v = v + (longint'(1) << (rank - 1));  // round half up
        end
        v = v >>> rank;
        if (v > 127) begin
            v = 127;
        end else if (v < -128) begin
            v = -128;
        end
        return {row[25:24], v[7:0]};
    endfunction

    function automatic bit drained();
        bit ok;
        ok = (owed == 0);
        for (int l = 0; l < NUM_LANES; l++) begin
            ok = ok && (exp_q[l].size() == 0) && (credits[l] == FIFO_DEPTH);
        end
        return ok;
    endfunction

    task automatic wait_drained();
        while (!drained()) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);  // let the last credit reach the arbiter
    endtask

    task automatic write_config(input int p);
        logic [31:0] e;
        for (int c = 0; c < NUM_CHANS; c++) begin
            e = CFG_TAB[p*NUM_CHANS + c];
            @(posedge clk);
            #1;
            cfg_we   = 1'b1;
            cfg_chan = CHAN_W'(c);
            cfg_bias = e[31:24];
            cfg_tail = e[23:8];
            cfg_rank = e[4:0];
        end
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    // each lane sends its next row of the phase as soon as it holds a credit
    task automatic send_phase(input int p);
        bit sent [NROWS];
        int pending;
        int pick;
        pending = 0;
        for (int r = 0; r < NROWS; r++) begin
            sent[r] = (int'(STIM[r][35:32]) != p);
            if (!sent[r]) pending++;
        end
        while (pending > 0) begin
            @(posedge clk);
            #1;
            in_valid = '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                pick = -1;
                for (int r = NROWS - 1; r >= 0; r--) begin
                    if (!sent[r] && int'(STIM[r][31:28]) == l) pick = r;
                end
                if (pick >= 0 && credits[l] > 0) begin
                    in_valid[l] = 1'b1;
                    acc_drv[l]  = STIM[pick][23:0];
                    chan_drv[l] = STIM[pick][25:24];
                    exp_q[l].push_back(expected_result(STIM[pick],
                        CFG_TAB[p*NUM_CHANS + int'(STIM[pick][25:24])]));
                    credits[l]--;
                    sent_beats[l]++;
                    sent[pick] = 1'b1;
                    pending--;
                end
            end
        end
        @(posedge clk);
        #1;
        in_valid = '0;
    endtask

    task automatic hold_output_credit(input int cycles);
        int start;
        @(posedge clk);
        withhold = 1'b1;
        start = out_beats;
        repeat (cycles) @(posedge clk);
        if (out_beats - start != OUT_CREDITS) begin
            errors++;
            $display("%0t: %0d beats came out while credit was held back, expected %0d",
                     $time, out_beats - start, OUT_CREDITS);
        end
        withhold = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitors and consumer
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!reset) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (in_credit[l]) begin
                    credits[l]++;
                    returned[l]++;
                    if (credits[l] > FIFO_DEPTH) begin
                        errors++;
                        $display("%0t: lane %0d returned more credits than it was given",
                                 $time, l);
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            out_beats++;
            owed++;
            if (out_beats - credits_given > OUT_CREDITS) begin
                errors++;
                $display("%0t: output beat sent without an output credit", $time);
            end
            if (int'(out_lane) >= NUM_LANES || exp_q[out_lane].size() == 0) begin
                errors++;
                $display("%0t: unexpected extra beat on lane %0d", $time, out_lane);
            end else begin
                exp_head = exp_q[out_lane].pop_front();
                if ({out_chan, out_data} != exp_head) begin
                    mismatches++;
                    $display("MISMATCH %0t: lane %0d got chan %0d data %0d, want chan %0d data %0d",
                             $time, out_lane, out_chan, $signed(out_data),
                             exp_head[9:8], $signed(exp_head[7:0]));
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        out_credit = 1'b0;
        if (!withhold && owed > 0) begin
            if (gap == 0) begin
                out_credit = 1'b1;
                owed--;
                credits_given++;
                gap = gap_tab[gap_idx];  // random 0..6 cycle pause
                gap_idx = (gap_idx + 1) % 64;
            end else begin
                gap--;
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", WATCHDOG);
        $display("Something failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed_rv = $urandom(2198);
        for (int i = 0; i < 64; i++) begin
            gap_tab[i] = $urandom_range(6, 0);
        end
        reset = 1'b1;
        in_valid = '0;
        cfg_we = 1'b0;
        cfg_chan = '0;
        cfg_bias = '0;
        cfg_tail = '0;
        cfg_rank = '0;
        out_credit = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            acc_drv[l] = '0;
            chan_drv[l] = '0;
            credits[l] = FIFO_DEPTH;
            sent_beats[l] = 0;
            returned[l] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (5) begin  // idle outputs before any input
            @(negedge clk);
            if (out_valid !== 1'b0 || in_credit !== '0) begin
                errors++;
                $display("%0t: outputs active after reset with no input", $time);
            end
        end
        for (int p = 0; p < NPHASES; p++) begin
            wait_drained();
            write_config(p);
            fork
                send_phase(p);
                if (p == HOLD_PHASE) hold_output_credit(HOLD_CYCLES);
            join
        end
        wait_drained();
        for (int l = 0; l < NUM_LANES; l++) begin
            if (returned[l] != sent_beats[l]) begin
                errors++;
                $display("lane %0d returned %0d input credits for %0d beats",
                         l, returned[l], sent_beats[l]);
            end
        end
        if (out_beats != NROWS) begin
            errors++;
            $display("%0d output beats seen for %0d rows sent", out_beats, NROWS);
        end
        $display("%0d beats checked, %0d mismatches, %0d other errors",
                 out_beats, mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
